/* common/axil_pkg.sv */
/*
  AXI4-Lite register offsets and response codes for the dirty tracker
*/
`include "dirty_consts.svh"

package axil_pkg;

  typedef enum logic [`AXI_ADDR_BITS-1:0] {
    REG_CTRL        = 4'h0,
    REG_STATUS      = 4'h4,
    REG_FLUSH_COUNT = 4'h8,
    REG_QUERY       = 4'hC
  } reg_off_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

endpackage

/* common/cache_line_pkg.sv */
/*
  cache line index views and the write port 0 requester type
*/
`include "dirty_consts.svh"

package cache_line_pkg;

  // bank picks the bit inside a RAM row
  typedef struct packed {
    logic [`BANK_BITS-1:0] bank;
    logic [`ROW_BITS-1:0]  row;
  } line_split_t;

  // same 8-bit line number seen flat or as bank/row
  typedef union packed {
    logic [`BANK_BITS+`ROW_BITS-1:0] flat;
    line_split_t                     split;
  } line_idx_u;

  // owner of RAM write port 0 with init first and fill last in priority
  typedef enum logic [1:0] {
    P0_NONE  = 2'd0,
    P0_INIT  = 2'd1,
    P0_CLEAR = 2'd2,
    P0_FILL  = 2'd3
  } p0_src_e;

endpackage

/* common/dirty_consts.svh */
/*
  dirty line tracker geometry and AXI4-Lite bus widths
*/
`ifndef DIRTY_CONSTS_SVH
`define DIRTY_CONSTS_SVH

`define LINE_COUNT 256
`define ROW_COUNT 32
`define ROW_BITS 5
`define BANK_BITS 3
`define AXI_ADDR_BITS 4
`define AXI_DATA_BITS 32

`endif

/* dirty/dirty_bits.sv */
/*
  256 dirty bits mapped onto the 32 x 8 RAM,
  init sequencer and write port 0 arbitration
*/
`include "dirty_consts.svh"

module dirty_bits (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     rd_en,
  input  cache_line_pkg::line_idx_u rd_line,
  output logic                     rd_dirty,
  input  logic                     init_start,
  output logic                     init_busy,
  input  logic                     clr_en,
  input  cache_line_pkg::line_idx_u clr_line,
  output logic                     clr_ack,
  input  logic                     fill_valid,
  input  cache_line_pkg::line_idx_u fill_line,
  input  logic                     fill_dirty,
  output logic                     fill_ready,
  input  logic                     store_valid,
  input  cache_line_pkg::line_idx_u store_line
);

  logic [`ROW_BITS-1:0]    init_row;
  logic [`BANK_BITS-1:0]   rd_bank_q;
  logic [7:0]              rd_data;
  cache_line_pkg::p0_src_e p0_src;
  logic                    wr0_en;
  logic [4:0]              wr0_addr;
  logic [7:0]              wr0_bit_en;
  logic [7:0]              wr0_data;

  function automatic logic [7:0] bank_onehot(input logic [`BANK_BITS-1:0] bank);
    logic [7:0] oh;
    oh = '0;
    oh[bank] = 1'b1;
    return oh;
  endfunction

  // init clears one row per cycle, 32 cycles in all
  always_ff @(posedge clk) begin
    if (rst) begin
      init_busy <= 1'b0;
      init_row  <= '0;
    end else if (init_busy) begin
      init_row <= init_row + 1'b1;
      if (init_row == `ROW_BITS'(`ROW_COUNT - 1))
        init_busy <= 1'b0;
    end else if (init_start) begin
      init_busy <= 1'b1;
      init_row  <= '0;
    end
  end

  // bank travels with the RAM read address
  always_ff @(posedge clk) begin
    if (rst)
      rd_bank_q <= '0;
    else if (rd_en)
      rd_bank_q <= rd_line.split.bank;
  end

  assign rd_dirty = rd_data[rd_bank_q];

  // init beats clear beats fill on port 0
  always_comb begin
    if (init_busy)
      p0_src = cache_line_pkg::P0_INIT;
    else if (clr_en)
      p0_src = cache_line_pkg::P0_CLEAR;
    else if (fill_valid)
      p0_src = cache_line_pkg::P0_FILL;
    else
      p0_src = cache_line_pkg::P0_NONE;
  end

  always_comb begin
    wr0_en     = 1'b1;
    wr0_addr   = '0;
    wr0_bit_en = '0;
    wr0_data   = '0;
    case (p0_src)
      cache_line_pkg::P0_INIT: begin
        wr0_addr   = init_row;
        wr0_bit_en = 8'hff;
      end
      cache_line_pkg::P0_CLEAR: begin
        wr0_addr   = clr_line.split.row;
        wr0_bit_en = bank_onehot(clr_line.split.bank);
      end
      cache_line_pkg::P0_FILL: begin
        wr0_addr   = fill_line.split.row;
        wr0_bit_en = bank_onehot(fill_line.split.bank);
        wr0_data   = {8{fill_dirty}};
      end
      default: wr0_en = 1'b0;
    endcase
  end

  assign clr_ack    = (p0_src == cache_line_pkg::P0_CLEAR);
  assign fill_ready = !init_busy && !clr_en;

  dirty_ram ram0 (
    .clk        (clk),
    .rst        (rst),
    .rd_addr    (rd_line.split.row),
    .rd_en      (rd_en),
    .rd_data    (rd_data),
    .wr0_en     (wr0_en),
    .wr0_addr   (wr0_addr),
    .wr0_bit_en (wr0_bit_en),
    .wr0_data   (wr0_data),
    .wr1_en     (store_valid),
    .wr1_addr   (store_line.split.row),
    .wr1_bit_en (bank_onehot(store_line.split.bank)),
    .wr1_data   (8'hff)
  );

endmodule

/* dirty/dirty_ram.sv */
/*
  32 x 8 dirty bit RAM with per-bit write enables,
  one registered-address read port and two write ports
*/
`include "dirty_consts.svh"

module dirty_ram (
  input  logic       clk,
  input  logic       rst,
  input  logic [4:0] rd_addr,
  input  logic       rd_en,
  output logic [7:0] rd_data,
  input  logic       wr0_en,
  input  logic [4:0] wr0_addr,
  input  logic [7:0] wr0_bit_en,
  input  logic [7:0] wr0_data,
  input  logic       wr1_en,
  input  logic [4:0] wr1_addr,
  input  logic [7:0] wr1_bit_en,
  input  logic [7:0] wr1_data
);

  logic [7:0]           mem [`ROW_COUNT];
  logic [`ROW_BITS-1:0] rd_addr_q;

  // port 1 comes second so its bits win on a collision
  always_ff @(posedge clk) begin
    for (int b = 0; b < 8; b++) begin
      if (wr0_en && wr0_bit_en[b])
        mem[wr0_addr][b] <= wr0_data[b];
      if (wr1_en && wr1_bit_en[b])
        mem[wr1_addr][b] <= wr1_data[b];
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      rd_addr_q <= '0;
    else if (rd_en)
      rd_addr_q <= rd_addr;
  end

  assign rd_data = mem[rd_addr_q];

endmodule

/* list.f */
+incdir+common
common/cache_line_pkg.sv
common/axil_pkg.sv
dirty/dirty_ram.sv
dirty/dirty_bits.sv
src/flush_scanner.sv
src/dirty_csr_axil.sv
src/dirty_tracker_top.sv
test/clock_gen.sv
test/tb_dirty_tracker.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the dirty tracker testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f list.f --top-module tb_dirty_tracker -o tb_dirty_tracker
./obj_dir/tb_dirty_tracker | tee sim.log
if grep -qF '*** PASSED ***' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* src/dirty_csr_axil.sv */
/*
  AXI4-Lite slave: control, status, flush count
  and single line dirty query registers
*/
`include "dirty_consts.svh"

module dirty_csr_axil (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [`AXI_ADDR_BITS-1:0] awaddr,
  input  logic                      wvalid,
  output logic                      wready,
  input  logic [`AXI_DATA_BITS-1:0] wdata,
  output logic                      bvalid,
  input  logic                      bready,
  output logic [1:0]                bresp,
  input  logic                      arvalid,
  output logic                      arready,
  input  logic [`AXI_ADDR_BITS-1:0] araddr,
  output logic                      rvalid,
  input  logic                      rready,
  output logic [`AXI_DATA_BITS-1:0] rdata,
  output logic [1:0]                rresp,
  input  logic                      flush_busy,
  input  logic                      init_busy,
  input  logic [8:0]                flush_count,
  input  logic                      rd_dirty,
  output logic                      flush_start,
  output logic                      init_start,
  output logic                      q_rd_en,
  output logic [7:0]                q_line
);

  logic                      aw_got, w_got;
  axil_pkg::reg_off_e        aw_off_q, wr_off, ar_off_q;
  logic [`AXI_DATA_BITS-1:0] w_data_q, wr_data;
  logic                      wr_fire;
  logic                      rd_pend1, rd_pend2, q_err_q;

  // AW and W may arrive apart, the write fires once both are held
  assign awready = !aw_got && !bvalid;
  assign wready  = !w_got && !bvalid;
  assign wr_fire = (aw_got || (awvalid && awready)) && (w_got || (wvalid && wready));
  assign wr_off  = aw_got ? aw_off_q : axil_pkg::reg_off_e'(awaddr);
  assign wr_data = w_got ? w_data_q : wdata;
  assign bresp   = axil_pkg::RESP_OKAY;

  always_ff @(posedge clk) begin
    if (awvalid && awready)
      aw_off_q <= axil_pkg::reg_off_e'(awaddr);
    if (wvalid && wready)
      w_data_q <= wdata;
    if (wr_fire && wr_off == axil_pkg::REG_QUERY)
      q_line <= wr_data[7:0];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      aw_got      <= 1'b0;
      w_got       <= 1'b0;
      bvalid      <= 1'b0;
      flush_start <= 1'b0;
      init_start  <= 1'b0;
    end else begin
      flush_start <= 1'b0;
      init_start  <= 1'b0;
      if (bvalid && bready)
        bvalid <= 1'b0;
      if (wr_fire) begin
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        bvalid <= 1'b1;
        // starts while busy are dropped, init wins over flush
        if (wr_off == axil_pkg::REG_CTRL && !flush_busy && !init_busy) begin
          init_start  <= wr_data[1];
          flush_start <= wr_data[0] && !wr_data[1];
        end
      end else begin
        aw_got <= aw_got || (awvalid && awready);
        w_got  <= w_got || (wvalid && wready);
      end
    end
  end

  // read pipe: latch offset, then RAM read, then return data
  assign arready = !rd_pend1 && !rd_pend2 && !rvalid;
  assign q_rd_en = rd_pend1 && ar_off_q == axil_pkg::REG_QUERY && !flush_busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pend1 <= 1'b0;
      rd_pend2 <= 1'b0;
      rvalid   <= 1'b0;
    end else begin
      rd_pend1 <= arvalid && arready;
      rd_pend2 <= rd_pend1;
      if (rd_pend2)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (arvalid && arready)
      ar_off_q <= axil_pkg::reg_off_e'(araddr);
    if (rd_pend1)
      q_err_q <= ar_off_q == axil_pkg::REG_QUERY && flush_busy;
    if (rd_pend2) begin
      rresp <= q_err_q ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
      case (ar_off_q)
        axil_pkg::REG_STATUS:      rdata <= {30'b0, init_busy, flush_busy};
        axil_pkg::REG_FLUSH_COUNT: rdata <= {23'b0, flush_count};
        axil_pkg::REG_QUERY:       rdata <= {31'b0, rd_dirty && !q_err_q};
        default:                   rdata <= '0;
      endcase
    end
  end

endmodule

/* src/dirty_tracker_top.sv */
/*
  dirty tracker top: dirty bit store, flush scanner,
  AXI4-Lite registers and the shared read port select
*/
`include "dirty_consts.svh"

module dirty_tracker_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      store_valid,
  input  logic [7:0]                store_line,
  input  logic                      fill_valid,
  input  logic [7:0]                fill_line,
  input  logic                      fill_dirty,
  output logic                      fill_ready,
  output logic                      wb_valid,
  output logic [7:0]                wb_line,
  input  logic                      wb_ready,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [`AXI_ADDR_BITS-1:0] awaddr,
  input  logic                      wvalid,
  output logic                      wready,
  input  logic [`AXI_DATA_BITS-1:0] wdata,
  output logic                      bvalid,
  input  logic                      bready,
  output logic [1:0]                bresp,
  input  logic                      arvalid,
  output logic                      arready,
  input  logic [`AXI_ADDR_BITS-1:0] araddr,
  output logic                      rvalid,
  input  logic                      rready,
  output logic [`AXI_DATA_BITS-1:0] rdata,
  output logic [1:0]                rresp
);

  logic                      init_start, flush_start;
  logic                      init_busy, flush_busy;
  logic                      rd_en, rd_dirty;
  cache_line_pkg::line_idx_u rd_line;
  logic                      scan_rd_en;
  cache_line_pkg::line_idx_u scan_rd_line;
  logic                      clr_en, clr_ack;
  cache_line_pkg::line_idx_u clr_line;
  logic [8:0]                flush_count;
  logic                      q_rd_en;
  logic [7:0]                q_line;

  // scanner owns the read port for the whole flush
  assign rd_en   = flush_busy ? scan_rd_en : q_rd_en;
  assign rd_line = flush_busy ? scan_rd_line.flat : q_line;

  dirty_bits bits0 (
    .clk         (clk),
    .rst         (rst),
    .rd_en       (rd_en),
    .rd_line     (rd_line),
    .rd_dirty    (rd_dirty),
    .init_start  (init_start),
    .init_busy   (init_busy),
    .clr_en      (clr_en),
    .clr_line    (clr_line),
    .clr_ack     (clr_ack),
    .fill_valid  (fill_valid),
    .fill_line   (fill_line),
    .fill_dirty  (fill_dirty),
    .fill_ready  (fill_ready),
    .store_valid (store_valid),
    .store_line  (store_line)
  );

  flush_scanner scan0 (
    .clk         (clk),
    .rst         (rst),
    .start       (flush_start),
    .busy        (flush_busy),
    .rd_en       (scan_rd_en),
    .rd_line     (scan_rd_line),
    .rd_dirty    (rd_dirty),
    .clr_en      (clr_en),
    .clr_line    (clr_line),
    .clr_ack     (clr_ack),
    .wb_valid    (wb_valid),
    .wb_line     (wb_line),
    .wb_ready    (wb_ready),
    .flush_count (flush_count)
  );

  dirty_csr_axil csr0 (
    .clk         (clk),
    .rst         (rst),
    .awvalid     (awvalid),
    .awready     (awready),
    .awaddr      (awaddr),
    .wvalid      (wvalid),
    .wready      (wready),
    .wdata       (wdata),
    .bvalid      (bvalid),
    .bready      (bready),
    .bresp       (bresp),
    .arvalid     (arvalid),
    .arready     (arready),
    .araddr      (araddr),
    .rvalid      (rvalid),
    .rready      (rready),
    .rdata       (rdata),
    .rresp       (rresp),
    .flush_busy  (flush_busy),
    .init_busy   (init_busy),
    .flush_count (flush_count),
    .rd_dirty    (rd_dirty),
    .flush_start (flush_start),
    .init_start  (init_start),
    .q_rd_en     (q_rd_en),
    .q_line      (q_line)
  );

endmodule

/* src/flush_scanner.sv */
/*
  flush FSM: reads every line in order, hands dirty ones
  to the write-back port, clears them and counts them
*/
`include "dirty_consts.svh"

module flush_scanner (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  output logic                      busy,
  output logic                      rd_en,
  output cache_line_pkg::line_idx_u rd_line,
  input  logic                      rd_dirty,
  output logic                      clr_en,
  output cache_line_pkg::line_idx_u clr_line,
  input  logic                      clr_ack,
  output logic                      wb_valid,
  output logic [7:0]                wb_line,
  input  logic                      wb_ready,
  output logic [8:0]                flush_count
);

  localparam logic [2:0] S_IDLE  = 3'd0;
  localparam logic [2:0] S_READ  = 3'd1;
  localparam logic [2:0] S_CHECK = 3'd2;
  localparam logic [2:0] S_WB    = 3'd3;
  localparam logic [2:0] S_CLEAR = 3'd4;

  logic [2:0] state;
  logic [7:0] line_q;
  logic       last_line;

  assign last_line = (line_q == 8'(`LINE_COUNT - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= S_IDLE;
      line_q      <= '0;
      flush_count <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            line_q      <= '0;
            flush_count <= '0;
            state       <= S_READ;
          end
        end
        S_READ: state <= S_CHECK;
        S_CHECK: begin
          if (rd_dirty)
            state <= S_WB;
          else if (last_line)
            state <= S_IDLE;
          else begin
            line_q <= line_q + 1'b1;
            state  <= S_READ;
          end
        end
        // line index is held stable while write-back stalls
        S_WB: begin
          if (wb_ready) begin
            flush_count <= flush_count + 1'b1;
            state       <= S_CLEAR;
          end
        end
        S_CLEAR: begin
          if (clr_ack) begin
            if (last_line)
              state <= S_IDLE;
            else begin
              line_q <= line_q + 1'b1;
              state  <= S_READ;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign busy     = (state != S_IDLE);
  assign rd_en    = (state == S_READ);
  assign rd_line  = line_q;
  assign clr_en   = (state == S_CLEAR);
  assign clr_line = line_q;
  assign wb_valid = (state == S_WB);
  assign wb_line  = line_q;

endmodule

/* test/clock_gen.sv */
/*
  testbench clock and reset source
  10 unit clock period, reset held for 16 cycles
*/
module clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // release one unit after the edge, like every other driven input
  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

/* test/dirty_trace.txt */
# command  arg1  arg2, all values hex
# INIT - -, STORE line -, FILL line dirty, QUERY line expected_bit
# FLUSH line_to_store_again_mid_flush -, EXPECT flush_count sweep_all_lines
INIT   00 0
QUERY  00 0
QUERY  45 0
QUERY  ff 0
STORE  03 0
STORE  23 0
STORE  63 0
STORE  9a 0
QUERY  03 1
QUERY  23 1
QUERY  43 0
QUERY  63 1
QUERY  83 0
QUERY  9a 1
FILL   c5 1
FILL   23 0
QUERY  c5 1
QUERY  23 0
FLUSH  03 0
EXPECT 04 1
QUERY  03 1
QUERY  9a 0

/* test/tb_dirty_tracker.sv */
/*
  trace-driven testbench for the dirty tracker
  keeps a 256-bit reference dirty model, drives store, fill
  and AXI4-Lite traffic, and checks flush write-back order
*/
`include "dirty_consts.svh"

module tb_dirty_tracker;

  localparam int WAIT_LIMIT = 4000;

  logic        clk, rst;
  logic        store_valid, fill_valid, fill_dirty, fill_ready;
  logic [7:0]  store_line, fill_line, wb_line;
  logic        wb_valid, wb_ready;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic [3:0]  awaddr, araddr;
  logic [31:0] wdata, rdata;
  logic [1:0]  bresp, rresp;

  logic [`LINE_COUNT-1:0] model;
  logic [7:0]             wb_log[$];
  logic [7:0]             wb_held;
  bit                     wb_pending;
  bit                     timed_out;
  int                     errors, tests, passed, last_flush;
  int                     seed, rnd;
  string                  cur_test;

  clock_gen clk0 (
    .clk (clk),
    .rst (rst)
  );

  dirty_tracker_top dut0 (
    .clk (clk), .rst (rst),
    .store_valid (store_valid), .store_line (store_line),
    .fill_valid (fill_valid), .fill_line (fill_line),
    .fill_dirty (fill_dirty), .fill_ready (fill_ready),
    .wb_valid (wb_valid), .wb_line (wb_line), .wb_ready (wb_ready),
    .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
    .wvalid (wvalid), .wready (wready), .wdata (wdata),
    .bvalid (bvalid), .bready (bready), .bresp (bresp),
    .arvalid (arvalid), .arready (arready), .araddr (araddr),
    .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp)
  );

  // random write-back back-pressure
  initial begin
    seed     = 665;
    wb_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      rnd      = $random(seed);
      wb_ready = !rst && rnd[0];
    end
  end

  // record write-back transfers and check that each offer holds until accepted
  always @(negedge clk) begin
    if (wb_pending) begin
      assert (wb_valid && wb_line == wb_held) else begin
        $display("write-back offer dropped or changed line before wb_ready in %s", cur_test);
        errors++;
      end
    end
    if (wb_valid && wb_ready)
      wb_log.push_back(wb_line);
    wb_pending = wb_valid && !wb_ready;
    wb_held    = wb_line;
  end

  task automatic next_edge();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
    assert (exp == got) else begin
      $display("[FAIL] %s %s: expected %0h actual %0h", cur_test, what, exp, got);
      errors++;
    end
  endtask

  task automatic count_wait(inout int n, input string what);
    n++;
    if (n > WAIT_LIMIT) begin
      $display("timeout: no %s within %0d cycles in %s", what, WAIT_LIMIT, cur_test);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
    int n;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = addr;
    wdata   = data;
    n = 0;
    @(negedge clk);
    while (!(awready && wready) && !timed_out) begin
      count_wait(n, "awready/wready");
      @(negedge clk);
    end
    next_edge();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    @(negedge clk);
    while (!bvalid && !timed_out) begin
      count_wait(n, "bvalid");
      @(negedge clk);
    end
    if (!timed_out)
      check_value("bresp", 32'(axil_pkg::RESP_OKAY), 32'(bresp));
    next_edge();
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    data    = '0;
    resp    = '0;
    arvalid = 1'b1;
    araddr  = addr;
    n = 0;
    @(negedge clk);
    while (!arready && !timed_out) begin
      count_wait(n, "arready");
      @(negedge clk);
    end
    next_edge();
    arvalid = 1'b0;
    n = 0;
    @(negedge clk);
    while (!rvalid && !timed_out) begin
      count_wait(n, "rvalid");
      @(negedge clk);
    end
    data = rdata;
    resp = rresp;
    next_edge();
  endtask

  task automatic query_line(input logic [7:0] line, output logic [31:0] data,
                            output logic [1:0] resp);
    axi_write(axil_pkg::REG_QUERY, 32'(line));
    axi_read(axil_pkg::REG_QUERY, data, resp);
  endtask

  task automatic wait_status_clear(input int bit_idx, input string what);
    logic [31:0] d;
    logic [1:0]  r;
    int          n;
    n = 0;
    axi_read(axil_pkg::REG_STATUS, d, r);
    while (d[bit_idx] && !timed_out) begin
      count_wait(n, what);
      axi_read(axil_pkg::REG_STATUS, d, r);
    end
  endtask

  task automatic drive_store(input logic [7:0] line);
    store_valid = 1'b1;
    store_line  = line;
    next_edge();
    store_valid = 1'b0;
    model[line] = 1'b1;
  endtask

  task automatic drive_fill(input logic [7:0] line, input logic dirty);
    int n;
    fill_valid = 1'b1;
    fill_line  = line;
    fill_dirty = dirty;
    n = 0;
    @(negedge clk);
    while (!fill_ready && !timed_out) begin
      count_wait(n, "fill_ready");
      @(negedge clk);
    end
    next_edge();
    fill_valid  = 1'b0;
    model[line] = dirty;
  endtask

  function automatic bit line_in_log(input logic [7:0] line);
    foreach (wb_log[k])
      if (wb_log[k] == line)
        return 1'b1;
    return 1'b0;
  endfunction

  // flush, then re-dirty target once the scanner has cleared it
  task automatic run_flush(input logic [7:0] target);
    logic [7:0]  exp_lines[$];
    logic [31:0] d;
    logic [1:0]  r;
    int          n;
    for (int i = 0; i < `LINE_COUNT; i++)
      if (model[i])
        exp_lines.push_back(8'(i));
    wb_log.delete();
    axi_write(axil_pkg::REG_CTRL, 32'h1);
    axi_read(axil_pkg::REG_QUERY, d, r);
    check_value("query rresp during flush", 32'(axil_pkg::RESP_SLVERR), 32'(r));
    check_value("query rdata during flush", 32'h0, d);
    n = 0;
    while (!line_in_log(target) && !timed_out) begin
      count_wait(n, "write-back of the target line");
      next_edge();
    end
    // clear lands one cycle after the write-back transfer
    repeat (3) next_edge();
    drive_store(target);
    wait_status_clear(0, "end of flush");
    check_value("write-back count", 32'(exp_lines.size()), 32'(wb_log.size()));
    for (int k = 0; k < exp_lines.size() && k < wb_log.size(); k++)
      check_value($sformatf("write-back #%0d", k), 32'(exp_lines[k]), 32'(wb_log[k]));
    last_flush    = exp_lines.size();
    model         = '0;
    model[target] = 1'b1;
  endtask

  initial begin
    logic [47:0] cmd;
    logic [15:0] a, b;
    logic [31:0] d;
    logic [1:0]  r;
    string       text;
    int          fd, fields, lnum, err_start, n;
    {store_valid, fill_valid, fill_dirty, awvalid, wvalid, arvalid} = '0;
    {store_line, fill_line, awaddr, araddr, wdata} = '0;
    bready     = 1'b1;
    rready     = 1'b1;
    model      = '0;
    cur_test   = "reset";
    lnum       = 0;
    n          = 0;
    @(negedge clk);
    while (rst && !timed_out) begin
      count_wait(n, "reset release");
      @(negedge clk);
    end
    next_edge();
    fd = $fopen("test/dirty_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file test/dirty_trace.txt");
      errors++;
    end
    while (fd != 0 && !timed_out && $fgets(text, fd) > 0) begin
      lnum++;
      if (text.len() < 2 || text.getc(0) == "#")
        continue;
      fields    = $sscanf(text, "%s %h %h", cmd, a, b);
      err_start = errors;
      cur_test  = $sformatf("trace line %0d", lnum);
      if (fields != 3) begin
        $display("trace line %0d does not hold a command and two values", lnum);
        errors++;
      end else begin
        case (cmd)
          "INIT": begin
            cur_test = $sformatf("init (trace line %0d)", lnum);
            // dirty every line first so the init has bits to clear
            for (int i = 0; i < `LINE_COUNT; i++)
              drive_store(8'(i));
            axi_write(axil_pkg::REG_CTRL, 32'h2);
            check_value("fill_ready during init", 32'h0, 32'(fill_ready));
            wait_status_clear(1, "end of init");
            model = '0;
          end
          "STORE": begin
            cur_test = $sformatf("store %02h (trace line %0d)", a[7:0], lnum);
            drive_store(a[7:0]);
          end
          "FILL": begin
            cur_test = $sformatf("fill %02h (trace line %0d)", a[7:0], lnum);
            drive_fill(a[7:0], b[0]);
          end
          "QUERY": begin
            cur_test = $sformatf("query %02h (trace line %0d)", a[7:0], lnum);
            query_line(a[7:0], d, r);
            check_value("rresp", 32'(axil_pkg::RESP_OKAY), 32'(r));
            check_value("dirty bit", 32'(b), d);
            check_value("model bit", 32'(model[a[7:0]]), d);
          end
          "FLUSH": begin
            cur_test = $sformatf("flush (trace line %0d)", lnum);
            run_flush(a[7:0]);
          end
          "EXPECT": begin
            cur_test = $sformatf("expect count %0d (trace line %0d)", a, lnum);
            axi_read(axil_pkg::REG_FLUSH_COUNT, d, r);
            check_value("flush count", 32'(a), d);
            check_value("model flush count", 32'(last_flush), d);
            for (int i = 0; i < `LINE_COUNT && b[0] && !timed_out; i++) begin
              query_line(8'(i), d, r);
              check_value($sformatf("line %02h", i), 32'(model[i]), d);
            end
          end
          default: begin
            $display("trace line %0d has an unknown command", lnum);
            errors++;
          end
        endcase
      end
      tests++;
      if (errors == err_start) begin
        passed++;
        $display("test %-36s ok", cur_test);
      end else
        $display("test %-36s failed", cur_test);
    end
    if (fd != 0)
      $fclose(fd);
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests, passed, tests - passed, errors);
    if (errors == 0 && !timed_out)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule
